// ==== rtl/rv32_isa_pkg.sv ====
/*
 * RV32 ISA types shared by the memory datapath.
 * Word type, memory operation codes, the byte/halfword lane union
 * and the access size helper.
 */

package rv32_isa_pkg;

    // ========================================
    // Basic types
    // ========================================

    typedef logic [31:0] rv32_word; // Data and address word.

    // Memory operations issued on the data port.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // One word seen as little-endian byte lanes or halfword lanes.
    typedef union packed {
        logic [3:0][7:0]  bytes;  // bytes[0] is the lowest address.
        logic [1:0][15:0] halves;
    } rv32_lane_word;

    // ========================================
    // Helpers
    // ========================================

    // Log2 of the access size in bytes.
    function automatic logic [1:0] access_bytes_log2(mem_op_e op);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return 2'd1;
            MEM_LW, MEM_SW:          return 2'd2;
            default:                 return 2'd0; // Bytes and no-op.
        endcase
    endfunction

endpackage

// ==== rtl/mem_layout_pkg.sv ====
/*
 * Geometry of the banked main memory.
 * Bytes per word, the bit position of the word address
 * and the default depth in words.
 */

package mem_layout_pkg;

    // ========================================
    // Word geometry
    // ========================================

    // One byte-wide bank per byte lane.
    localparam int BYTES_PER_WORD = 4;

    // Byte offset bits below the word address.
    localparam int WORD_ADDR_LSB = 2;

    // ========================================
    // Depth
    // ========================================

    // 32 KiB of memory unless the top level says otherwise.
    localparam int DEFAULT_NUM_WORDS = 8192;

endpackage

// ==== rtl/byte_bank_ram.sv ====
/*
 * Byte-wide dual-port block RAM bank.
 * Port A reads only, port B reads and writes (read-first).
 */

`timescale 1ns/100ps

module byte_bank_ram #(
    parameter int ADDR_WIDTH = 13
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // Port A, read only.
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic                  rd_en_a,
    output logic [7:0]            rdata_a,
    // Port B, read/write.
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic                  rd_en_b,
    input  logic                  wr_en_b,
    input  logic [7:0]            wdata_b,
    output logic [7:0]            rdata_b
);

    logic [7:0] mem [2**ADDR_WIDTH];

    // Array write, no reset on contents.
    always_ff @(posedge clk) begin
        if (wr_en_b) begin
            mem[addr_b] <= wdata_b;
        end
    end

    // Registered reads. Port B sees the old byte on a same-edge write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            if (rd_en_a) begin
                rdata_a <= mem[addr_a];
            end
            if (rd_en_b) begin
                rdata_b <= mem[addr_b];
            end
        end
    end

endmodule

// ==== rtl/access_lane_decode.sv ====
/*
 * Data port access decode.
 * Alignment check, store byte enables and lane steering
 * of the store data, little-endian.
 */

`timescale 1ns/100ps

module access_lane_decode (
    input  rv32_isa_pkg::mem_op_e       data_op,
    input  logic [1:0]                  offset,
    input  rv32_isa_pkg::rv32_word      wdata,
    output logic [3:0]                  byte_en,
    output rv32_isa_pkg::rv32_lane_word lane_wdata,
    output logic                        misaligned
);

    // ========================================
    // Alignment
    // ========================================

    always_comb begin
        case (rv32_isa_pkg::access_bytes_log2(data_op))
            2'd1:    misaligned = offset[0]; // Halfword on odd byte.
            2'd2:    misaligned = |offset;
            default: misaligned = 1'b0;
        endcase
    end

    // ========================================
    // Store steering
    // ========================================

    always_comb begin
        byte_en    = 4'b0000;
        lane_wdata = wdata;

        case (data_op)
            rv32_isa_pkg::MEM_SB: begin
                // Same byte on every lane, enable picks one.
                lane_wdata.bytes = {4{wdata[7:0]}};
                byte_en          = 4'b0001 << offset;
            end
            rv32_isa_pkg::MEM_SH: begin
                lane_wdata.halves = {2{wdata[15:0]}};
                if (!misaligned) begin
                    byte_en = offset[1] ? 4'b1100 : 4'b0011;
                end
            end
            rv32_isa_pkg::MEM_SW: begin
                if (!misaligned) begin
                    byte_en = 4'b1111;
                end
            end
            default: begin
                byte_en = 4'b0000; // Loads never write.
            end
        endcase
    end

endmodule

// ==== rtl/rv32_main_memory.sv ====
/*
 * Banked main memory.
 * Four byte banks, range checks on both ports,
 * gated data writes and the registered fetch response.
 */

`timescale 1ns/100ps

module rv32_main_memory #(
    parameter int NUM_WORDS = mem_layout_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                        clk,
    input  logic                        arst_n,
    // Instruction port.
    input  logic                        instr_req,
    input  rv32_isa_pkg::rv32_word      instr_addr,
    output logic                        instr_valid,
    output logic                        instr_err,
    output rv32_isa_pkg::rv32_word      instr,
    // Data port.
    input  logic                        data_req,
    input  rv32_isa_pkg::rv32_word      data_addr,
    input  logic [3:0]                  byte_en,
    input  rv32_isa_pkg::rv32_lane_word lane_wdata,
    output logic                        data_in_range,
    output rv32_isa_pkg::rv32_word      bank_rdata
);

    localparam int ADDR_WIDTH     = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam int LSB            = mem_layout_pkg::WORD_ADDR_LSB;
    localparam int WORD_ADDR_BITS = 32 - LSB;
    localparam int NUM_BANKS      = mem_layout_pkg::BYTES_PER_WORD;
    localparam rv32_isa_pkg::rv32_word WORD_LIMIT = rv32_isa_pkg::rv32_word'(NUM_WORDS);

    logic [WORD_ADDR_BITS-1:0] instr_word_addr;
    logic [WORD_ADDR_BITS-1:0] data_word_addr;
    logic [ADDR_WIDTH-1:0]     instr_bank_addr;
    logic [ADDR_WIDTH-1:0]     data_bank_addr;
    logic                      instr_in_range;
    logic                      instr_unaligned;
    logic [NUM_BANKS-1:0]      bank_we;
    logic [NUM_BANKS-1:0][7:0] instr_bytes;
    logic [NUM_BANKS-1:0][7:0] data_bytes;

    // ========================================
    // Address slicing and range checks
    // ========================================

    assign instr_word_addr = instr_addr[31:LSB];
    assign data_word_addr  = data_addr[31:LSB];
    assign instr_bank_addr = instr_word_addr[ADDR_WIDTH-1:0];
    assign data_bank_addr  = data_word_addr[ADDR_WIDTH-1:0];

    assign instr_in_range  = {{LSB{1'b0}}, instr_word_addr} < WORD_LIMIT;
    assign data_in_range   = {{LSB{1'b0}}, data_word_addr} < WORD_LIMIT;
    assign instr_unaligned = |instr_addr[LSB-1:0]; // Fetch port only.

    // Nothing lands outside the array.
    assign bank_we = byte_en & {NUM_BANKS{data_req & data_in_range}};

    // ========================================
    // Banks
    // ========================================

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        byte_bank_ram #(
            .ADDR_WIDTH(ADDR_WIDTH)
        ) byte_bank_ram_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .addr_a  (instr_bank_addr),
            .rd_en_a (instr_req),
            .rdata_a (instr_bytes[i]),
            .addr_b  (data_bank_addr),
            .rd_en_b (data_req),
            .wr_en_b (bank_we[i]),
            .wdata_b (lane_wdata.bytes[i]),
            .rdata_b (data_bytes[i])
        );
    end

    assign bank_rdata = data_bytes; // Raw word, aligned later.

    // ========================================
    // Fetch response
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_valid <= 1'b0;
            instr_err   <= 1'b0;
        end else begin
            instr_valid <= instr_req;
            instr_err   <= instr_req & (instr_unaligned | !instr_in_range);
        end
    end

    assign instr = instr_err ? '0 : instr_bytes; // Zero on a bad fetch.

endmodule

// ==== rtl/load_response_align.sv ====
/*
 * Data port response stage.
 * Holds the access context for one cycle, then forms
 * valid, error and the extended load data.
 */

`timescale 1ns/100ps

module load_response_align (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   data_req,
    input  rv32_isa_pkg::mem_op_e  data_op,
    input  logic [1:0]             offset,
    input  logic                   misaligned,
    input  logic                   data_in_range,
    input  rv32_isa_pkg::rv32_word bank_rdata,
    output logic                   data_valid,
    output logic                   data_err,
    output rv32_isa_pkg::rv32_word load_data
);

    rv32_isa_pkg::mem_op_e       op_q;
    logic [1:0]                  offset_q;
    rv32_isa_pkg::rv32_lane_word word_view;
    logic [7:0]                  byte_sel;
    logic [15:0]                 half_sel;

    // ========================================
    // Request context
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_valid <= 1'b0;
            data_err   <= 1'b0;
        end else begin
            data_valid <= data_req;
            data_err   <= data_req & (misaligned | !data_in_range);
        end
    end

    always_ff @(posedge clk) begin
        if (data_req) begin
            op_q     <= data_op;
            offset_q <= offset;
        end
    end

    // ========================================
    // Lane extraction and extension
    // ========================================

    assign word_view = bank_rdata;
    assign byte_sel  = word_view.bytes[offset_q];
    assign half_sel  = word_view.halves[offset_q[1]];

    always_comb begin
        load_data = '0;
        if (data_valid && !data_err) begin
            case (op_q)
                rv32_isa_pkg::MEM_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
                rv32_isa_pkg::MEM_LBU: load_data = {24'h0, byte_sel};
                rv32_isa_pkg::MEM_LH:  load_data = {{16{half_sel[15]}}, half_sel};
                rv32_isa_pkg::MEM_LHU: load_data = {16'h0, half_sel};
                rv32_isa_pkg::MEM_LW:  load_data = word_view;
                default:               load_data = '0; // Stores return zero.
            endcase
        end
    end

endmodule

// ==== rtl/rv32_memory_top.sv ====
/*
 * Main memory top level.
 * Lane decode, banked memory and the data response stage.
 */

`timescale 1ns/100ps

module rv32_memory_top #(
    parameter int NUM_WORDS = mem_layout_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // Instruction port.
    input  logic                   instr_req,
    input  rv32_isa_pkg::rv32_word instr_addr,
    output logic                   instr_valid,
    output logic                   instr_err,
    output rv32_isa_pkg::rv32_word instr,
    // Data port.
    input  logic                   data_req,
    input  rv32_isa_pkg::mem_op_e  data_op,
    input  rv32_isa_pkg::rv32_word data_addr,
    input  rv32_isa_pkg::rv32_word data_wdata,
    output logic                   data_valid,
    output logic                   data_err,
    output rv32_isa_pkg::rv32_word load_data
);

    logic [1:0]                  offset;
    logic [3:0]                  byte_en;
    rv32_isa_pkg::rv32_lane_word lane_wdata;
    logic                        misaligned;
    logic                        data_in_range;
    rv32_isa_pkg::rv32_word      bank_rdata;

    assign offset = data_addr[mem_layout_pkg::WORD_ADDR_LSB-1:0];

    access_lane_decode access_lane_decode_inst (
        .data_op    (data_op),
        .offset     (offset),
        .wdata      (data_wdata),
        .byte_en    (byte_en),
        .lane_wdata (lane_wdata),
        .misaligned (misaligned)
    );

    rv32_main_memory #(
        .NUM_WORDS(NUM_WORDS)
    ) rv32_main_memory_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_req     (instr_req),
        .instr_addr    (instr_addr),
        .instr_valid   (instr_valid),
        .instr_err     (instr_err),
        .instr         (instr),
        .data_req      (data_req),
        .data_addr     (data_addr),
        .byte_en       (byte_en),
        .lane_wdata    (lane_wdata),
        .data_in_range (data_in_range),
        .bank_rdata    (bank_rdata)
    );

    load_response_align load_response_align_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_req      (data_req),
        .data_op       (data_op),
        .offset        (offset),
        .misaligned    (misaligned),
        .data_in_range (data_in_range),
        .bank_rdata    (bank_rdata),
        .data_valid    (data_valid),
        .data_err      (data_err),
        .load_data     (load_data)
    );

endmodule

// ==== testbench/tb_mem_model.svh ====
/*
 * Reference model of the main memory for the testbench.
 * Byte array, range and alignment rules, store update,
 * extended load and fetch prediction.
 */

`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

logic [7:0] model_mem [TB_NUM_WORDS*4]; // Little-endian byte image.

function automatic bit addr_in_range(input rv32_isa_pkg::rv32_word addr);
    return {2'b00, addr[31:2]} < 32'(TB_NUM_WORDS);
endfunction

function automatic bit model_data_err(input rv32_isa_pkg::mem_op_e op,
                                      input rv32_isa_pkg::rv32_word addr);
    bit mis;
    case (op)
        rv32_isa_pkg::MEM_LH, rv32_isa_pkg::MEM_LHU, rv32_isa_pkg::MEM_SH: mis = addr[0];
        rv32_isa_pkg::MEM_LW, rv32_isa_pkg::MEM_SW: mis = |addr[1:0];
        default: mis = 1'b0;
    endcase
    return mis || !addr_in_range(addr);
endfunction

function automatic bit model_instr_err(input rv32_isa_pkg::rv32_word addr);
    return (|addr[1:0]) || !addr_in_range(addr);
endfunction

function automatic void model_store(input rv32_isa_pkg::mem_op_e op,
                                    input rv32_isa_pkg::rv32_word addr,
                                    input rv32_isa_pkg::rv32_word wdata);
    int idx;
    idx = int'(addr[31:2]) * 4 + int'(addr[1:0]);
    if (model_data_err(op, addr)) begin
        return; // Bad stores leave memory alone.
    end
    case (op)
        rv32_isa_pkg::MEM_SB: model_mem[idx] = wdata[7:0];
        rv32_isa_pkg::MEM_SH: begin
            model_mem[idx]   = wdata[7:0];
            model_mem[idx+1] = wdata[15:8];
        end
        rv32_isa_pkg::MEM_SW: begin
            for (int i = 0; i < 4; i++) begin
                model_mem[idx+i] = wdata[8*i +: 8];
            end
        end
        default: ;
    endcase
endfunction

function automatic rv32_isa_pkg::rv32_word model_load(input rv32_isa_pkg::mem_op_e op,
                                                     input rv32_isa_pkg::rv32_word addr);
    int         idx;
    logic [7:0]  b;
    logic [15:0] h;
    if (model_data_err(op, addr)) begin
        return '0;
    end
    idx = int'(addr[31:2]) * 4 + int'(addr[1:0]);
    b   = model_mem[idx];
    h   = {model_mem[idx+1], b};
    case (op)
        rv32_isa_pkg::MEM_LB:  return {{24{b[7]}}, b};
        rv32_isa_pkg::MEM_LBU: return {24'h0, b};
        rv32_isa_pkg::MEM_LH:  return {{16{h[15]}}, h};
        rv32_isa_pkg::MEM_LHU: return {16'h0, h};
        rv32_isa_pkg::MEM_LW:
            return {model_mem[idx+3], model_mem[idx+2], model_mem[idx+1], model_mem[idx]};
        default: return '0; // Stores return nothing.
    endcase
endfunction

function automatic rv32_isa_pkg::rv32_word model_fetch(input rv32_isa_pkg::rv32_word addr);
    int idx;
    if (model_instr_err(addr)) begin
        return '0;
    end
    idx = int'(addr[31:2]) * 4;
    return {model_mem[idx+3], model_mem[idx+2], model_mem[idx+1], model_mem[idx]};
endfunction

`endif

// ==== testbench/tb_rv32_memory.sv ====
/*
 * Testbench for the RV32 main memory.
 * Clock, reset, directed and random stimulus, the response
 * comparison process, watchdog and the final report.
 */

`timescale 1ns/100ps

module tb_rv32_memory;

    localparam int  TB_NUM_WORDS = 256;
    localparam time CLK_PERIOD   = 40ns;
    localparam int  TOTAL_REQ    = 1100; // Requests and idle cycles of all tests.
    localparam int  MARGIN       = 300;

    logic clk;
    logic arst_n;
    logic instr_req;
    logic instr_valid;
    logic instr_err;
    logic data_req;
    logic data_valid;
    logic data_err;
    rv32_isa_pkg::rv32_word instr_addr;
    rv32_isa_pkg::rv32_word instr;
    rv32_isa_pkg::mem_op_e  data_op;
    rv32_isa_pkg::rv32_word data_addr;
    rv32_isa_pkg::rv32_word data_wdata;
    rv32_isa_pkg::rv32_word load_data;

    int cycle  = 0;
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int test_start_errors = 0;

    int                     instr_due_q[$];
    rv32_isa_pkg::rv32_word instr_exp_q[$];
    bit                     instr_experr_q[$];
    int                     data_due_q[$];
    rv32_isa_pkg::rv32_word data_exp_q[$];
    bit                     data_experr_q[$];

    `include "tb_mem_model.svh"

    rv32_memory_top #(
        .NUM_WORDS(TB_NUM_WORDS)
    ) rv32_memory_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_valid (instr_valid),
        .instr_err   (instr_err),
        .instr       (instr),
        .data_req    (data_req),
        .data_op     (data_op),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_valid  (data_valid),
        .data_err    (data_err),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ========================================
    // Stimulus helpers
    // ========================================

    // One cycle of requests. Expectations are taken before the store (read-first).
    task automatic issue(input bit i_req, input rv32_isa_pkg::rv32_word i_addr,
                         input bit d_req, input rv32_isa_pkg::mem_op_e op,
                         input rv32_isa_pkg::rv32_word d_addr,
                         input rv32_isa_pkg::rv32_word wdata);
        @(negedge clk);
        instr_req  = i_req;
        instr_addr = i_addr;
        data_req   = d_req;
        data_op    = op;
        data_addr  = d_addr;
        data_wdata = wdata;
        if (i_req) begin
            instr_due_q.push_back(cycle + 1);
            instr_exp_q.push_back(model_fetch(i_addr));
            instr_experr_q.push_back(model_instr_err(i_addr));
        end
        if (d_req) begin
            data_due_q.push_back(cycle + 1);
            data_exp_q.push_back(model_load(op, d_addr));
            data_experr_q.push_back(model_data_err(op, d_addr));
            model_store(op, d_addr, wdata);
        end
    endtask

    task automatic data_access(input rv32_isa_pkg::mem_op_e op,
                               input rv32_isa_pkg::rv32_word addr,
                               input rv32_isa_pkg::rv32_word wdata);
        issue(1'b0, '0, 1'b1, op, addr, wdata);
    endtask

    task automatic fetch(input rv32_isa_pkg::rv32_word addr);
        issue(1'b1, addr, 1'b0, rv32_isa_pkg::MEM_NONE, '0, '0);
    endtask

    // Idle, let the last responses come back, then report.
    task automatic close_test(input string name);
        issue(1'b0, '0, 1'b0, rv32_isa_pkg::MEM_NONE, '0, '0);
        repeat (3) @(negedge clk);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ========================================
    // Comparison
    // ========================================

    always @(negedge clk) begin
        if (arst_n) begin
            if (instr_due_q.size() > 0 && instr_due_q[0] == cycle) begin
                checks++;
                if (!instr_valid) begin
                    $display("Fetch response missing at %0t", $time);
                    errors++;
                end else if (instr_err !== instr_experr_q[0] || instr !== instr_exp_q[0]) begin
                    $display("ERROR %0t: fetch got err %b instr %h, expected err %b instr %h",
                             $time, instr_err, instr, instr_experr_q[0], instr_exp_q[0]);
                    errors++;
                end
                void'(instr_due_q.pop_front());
                void'(instr_exp_q.pop_front());
                void'(instr_experr_q.pop_front());
            end else if (instr_valid) begin
                $display("Fetch valid strobe without a request at %0t", $time);
                errors++;
            end
            if (data_due_q.size() > 0 && data_due_q[0] == cycle) begin
                checks++;
                if (!data_valid) begin
                    $display("Data response missing at %0t", $time);
                    errors++;
                end else if (data_err !== data_experr_q[0] || load_data !== data_exp_q[0]) begin
                    $display("ERROR %0t: data got err %b load %h, expected err %b load %h",
                             $time, data_err, load_data, data_experr_q[0], data_exp_q[0]);
                    errors++;
                end
                void'(data_due_q.pop_front());
                void'(data_exp_q.pop_front());
                void'(data_experr_q.pop_front());
            end else if (data_valid) begin
                $display("Data valid strobe without a request at %0t", $time);
                errors++;
            end
        end
    end

    // ========================================
    // Watchdog
    // ========================================

    initial begin
        #((TOTAL_REQ + MARGIN + 10) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    // ========================================
    // Tests
    // ========================================

    initial begin
        int                     idx;
        int                     sidx;
        int                     roll;
        rv32_isa_pkg::rv32_word word;
        rv32_isa_pkg::mem_op_e  op;

        void'($urandom(32'hcd1c));
        arst_n     = 1'b0;
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_op    = rv32_isa_pkg::MEM_NONE;
        data_addr  = '0;
        data_wdata = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        // Quiet outputs after reset.
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (instr_valid || data_valid || instr_err || data_err) begin
                $display("ERROR %0t: response strobe high with no request", $time);
                errors++;
            end
        end
        close_test("idle after reset");

        for (int w = 0; w < TB_NUM_WORDS; w++) begin
            data_access(rv32_isa_pkg::MEM_SW, rv32_isa_pkg::rv32_word'(w * 4), $urandom);
        end
        repeat (64) begin
            idx = int'($urandom_range(0, TB_NUM_WORDS - 1));
            data_access(rv32_isa_pkg::MEM_SW, rv32_isa_pkg::rv32_word'(idx * 4), $urandom);
            data_access(rv32_isa_pkg::MEM_LW, rv32_isa_pkg::rv32_word'(idx * 4), '0);
        end
        close_test("word store and load");

        for (int w = 0; w < 16; w++) begin
            for (int off = 0; off < 4; off++) begin
                data_access(rv32_isa_pkg::MEM_SB, rv32_isa_pkg::rv32_word'(w * 4 + off), $urandom);
                data_access(rv32_isa_pkg::MEM_LW, rv32_isa_pkg::rv32_word'(w * 4), '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                data_access(rv32_isa_pkg::MEM_SH, rv32_isa_pkg::rv32_word'(w * 4 + off), $urandom);
                data_access(rv32_isa_pkg::MEM_LW, rv32_isa_pkg::rv32_word'(w * 4), '0);
            end
        end
        close_test("byte and halfword stores");

        for (int w = 16; w < 32; w++) begin
            word = (w % 2 == 1) ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f);
            data_access(rv32_isa_pkg::MEM_SW, rv32_isa_pkg::rv32_word'(w * 4), word);
            for (int off = 0; off < 4; off++) begin
                data_access(rv32_isa_pkg::MEM_LB, rv32_isa_pkg::rv32_word'(w * 4 + off), '0);
                data_access(rv32_isa_pkg::MEM_LBU, rv32_isa_pkg::rv32_word'(w * 4 + off), '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                data_access(rv32_isa_pkg::MEM_LH, rv32_isa_pkg::rv32_word'(w * 4 + off), '0);
                data_access(rv32_isa_pkg::MEM_LHU, rv32_isa_pkg::rv32_word'(w * 4 + off), '0);
            end
        end
        close_test("extended loads");

        // Misaligned accesses around word 40.
        for (int off = 1; off < 4; off++) begin
            data_access(rv32_isa_pkg::MEM_LW, rv32_isa_pkg::rv32_word'(160 + off), '0);
            data_access(rv32_isa_pkg::MEM_SW, rv32_isa_pkg::rv32_word'(160 + off), $urandom);
            data_access(rv32_isa_pkg::MEM_LW, 32'd160, '0);
        end
        for (int off = 1; off < 4; off += 2) begin
            data_access(rv32_isa_pkg::MEM_LH, rv32_isa_pkg::rv32_word'(160 + off), '0);
            data_access(rv32_isa_pkg::MEM_LHU, rv32_isa_pkg::rv32_word'(160 + off), '0);
            data_access(rv32_isa_pkg::MEM_SH, rv32_isa_pkg::rv32_word'(160 + off), $urandom);
            data_access(rv32_isa_pkg::MEM_LW, 32'd160, '0);
        end
        // Out of range, the bank index would alias word 0.
        data_access(rv32_isa_pkg::MEM_SW, 32'd1024, $urandom);
        data_access(rv32_isa_pkg::MEM_SB, 32'd1025, $urandom);
        data_access(rv32_isa_pkg::MEM_LW, 32'd1028, '0);
        data_access(rv32_isa_pkg::MEM_LB, 32'hffff_fff0, '0);
        data_access(rv32_isa_pkg::MEM_SW, 32'h8000_0000, $urandom);
        data_access(rv32_isa_pkg::MEM_LW, 32'd0, '0);
        fetch(32'd161);
        fetch(32'd162);
        fetch(32'd1024);
        fetch(32'hffff_fffc);
        fetch(32'd160);
        close_test("error accesses");

        repeat (200) begin
            idx  = int'($urandom_range(0, 15));
            roll = int'($urandom_range(0, 3));
            sidx = (roll == 0) ? idx : int'($urandom_range(0, 15));
            case ($urandom_range(0, 3))
                0:       op = rv32_isa_pkg::MEM_SW;
                1:       op = rv32_isa_pkg::MEM_SB;
                2:       op = rv32_isa_pkg::MEM_LW;
                default: op = rv32_isa_pkg::MEM_LBU;
            endcase
            issue(1'b1, rv32_isa_pkg::rv32_word'(idx * 4), 1'b1, op,
                  rv32_isa_pkg::rv32_word'(sidx * 4 + ((op == rv32_isa_pkg::MEM_SB) ? roll : 0)),
                  $urandom);
        end
        close_test("concurrent fetch and data");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+testbench
rtl/rv32_isa_pkg.sv
rtl/mem_layout_pkg.sv
rtl/byte_bank_ram.sv
rtl/access_lane_decode.sv
rtl/rv32_main_memory.sv
rtl/load_response_align.sv
rtl/rv32_memory_top.sv
testbench/tb_rv32_memory.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f all.f --top-module tb_rv32_memory \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
